// ==== source/telemetry_pkg.sv ====
// Telemetry transmitter definitions
`default_nettype none

package telemetry_pkg;

	// clock cycles per serial bit
	localparam int unsigned BIT_TICKS = 8;
	// width of the bit-period counter
	localparam int unsigned TICK_W = $clog2(BIT_TICKS);

	// start bit, eight data bits, stop bit
	localparam int unsigned FRAME_BITS = 10;
	// width of the bit index inside a frame
	localparam int unsigned BIT_W = $clog2(FRAME_BITS);

	// analog multiplexer channels
	localparam int unsigned NUM_CHANNELS = 8;
	localparam int unsigned CHAN_W = $clog2(NUM_CHANNELS);

	// upper nibble of every header byte
	localparam logic [3:0] HEADER_TAG = 4'hC;

	// which of the two frames of a pair is on the line
	typedef enum logic {
		FRAME_HEADER,
		FRAME_SAMPLE
	} frame_kind_t;

	// one frame request from the scheduler
	typedef struct packed {
		frame_kind_t kind;
		logic [7:0]  payload;
	} tx_frame_t;

	// line interface state seen by the rest of the design
	typedef struct packed {
		logic busy;
		logic error;
	} line_status_t;

	// latched conversion result with its channel
	typedef struct packed {
		logic [CHAN_W-1:0] channel;
		logic [7:0]        value;
	} sample_t;

	// acquisition sequencing
	typedef enum logic [2:0] {
		SEQ_MUX,
		SEQ_SETTLE,
		SEQ_START,
		SEQ_EOC_HI,
		SEQ_EOC_LO,
		SEQ_LATCH,
		SEQ_HANDOFF,
		SEQ_DRAIN
	} seq_state_t;

	// frame scheduling
	typedef enum logic [1:0] {
		SCHED_IDLE,
		SCHED_HEADER_WAIT,
		SCHED_SAMPLE_WAIT
	} sched_state_t;

	// line interface
	typedef enum logic [1:0] {
		LINE_IDLE,
		LINE_LOAD,
		LINE_SEND,
		LINE_WAIT_END
	} line_state_t;

	// serial shifting
	typedef enum logic {
		SHIFT_IDLE,
		SHIFT_RUN
	} shift_state_t;

endpackage

`default_nettype wire

// ==== source/sample_sequencer.sv ====
// Acquisition sequencer
`default_nettype none
`timescale 1ns/1ps

module sample_sequencer (
	input  wire                                 clock,
	input  wire                                 rst_n,
	input  wire                                 eoc,
	input  wire  [7:0]                          data_in,
	input  wire                                 rdy,
	output logic                                soc,
	output logic                                load_dato,
	output logic                                mux_en,
	output logic [telemetry_pkg::CHAN_W-1:0]    canale,
	output logic                                send_data,
	output telemetry_pkg::sample_t              sample
);

	import telemetry_pkg::*;

	seq_state_t state;

	// last channel before wrapping back to zero
	localparam logic [CHAN_W-1:0] LAST_CHANNEL = CHAN_W'(NUM_CHANNELS - 1);

	// control machine
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state     <= SEQ_MUX;
			soc       <= 1'b0;
			load_dato <= 1'b0;
			mux_en    <= 1'b0;
			canale    <= '0;
			send_data <= 1'b0;
		end else begin
			case (state)
				SEQ_MUX: begin
					// select the current channel on the external mux
					mux_en <= 1'b1;
					state  <= SEQ_SETTLE;
				end
				SEQ_SETTLE: begin
					// one cycle for the mux output to settle
					state <= SEQ_START;
				end
				SEQ_START: begin
					soc   <= 1'b1;
					state <= SEQ_EOC_HI;
				end
				SEQ_EOC_HI: begin
					// converter signals it has started
					if (eoc) begin
						state <= SEQ_EOC_LO;
					end
				end
				SEQ_EOC_LO: begin
					// end of conversion, data_in already valid
					if (!eoc) begin
						load_dato <= 1'b1;
						state     <= SEQ_LATCH;
					end
				end
				SEQ_LATCH: begin
					// byte is captured in this cycle by the payload block
					load_dato <= 1'b0;
					soc       <= 1'b0;
					mux_en    <= 1'b0;
					send_data <= 1'b1;
					if (canale == LAST_CHANNEL) begin
						canale <= '0;
					end else begin
						canale <= canale + 1'b1;
					end
					state <= SEQ_HANDOFF;
				end
				SEQ_HANDOFF: begin
					// scheduler took the sample once rdy is up
					if (rdy) begin
						send_data <= 1'b0;
						state     <= SEQ_DRAIN;
					end
				end
				SEQ_DRAIN: begin
					// both frames done when rdy drops
					if (!rdy) begin
						state <= SEQ_MUX;
					end
				end
				default: begin
					state <= SEQ_MUX;
				end
			endcase
		end
	end

	// sample payload, taken while load_dato is high
	always_ff @(posedge clock) begin
		if (state == SEQ_LATCH) begin
			sample.channel <= canale;
			sample.value   <= data_in;
		end
	end

endmodule

`default_nettype wire

// ==== source/frame_scheduler.sv ====
// Frame scheduler
`default_nettype none
`timescale 1ns/1ps

module frame_scheduler (
	input  wire                         clock,
	input  wire                         rst_n,
	input  wire                         send_data,
	input  telemetry_pkg::sample_t      sample,
	input  wire                         confirm,
	output logic                        rdy,
	output logic                        shot,
	output logic                        add_mpx2,
	output telemetry_pkg::tx_frame_t    frame
);

	import telemetry_pkg::*;

	sched_state_t state;
	logic [7:0]   header_byte;
	logic         start_pair;
	logic         start_sample;

	// tag nibble, a zero bit, then the channel
	assign header_byte = {HEADER_TAG, 1'b0, sample.channel};

	// first frame of a pair
	assign start_pair = (state == SCHED_IDLE) && send_data;
	// second frame once the header is confirmed
	assign start_sample = (state == SCHED_HEADER_WAIT) && confirm;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state    <= SCHED_IDLE;
			rdy      <= 1'b0;
			shot     <= 1'b0;
			add_mpx2 <= 1'b0;
		end else begin
			// shot is a single-cycle strobe
			shot <= 1'b0;
			case (state)
				SCHED_IDLE: begin
					if (start_pair) begin
						rdy   <= 1'b1;
						shot  <= 1'b1;
						state <= SCHED_HEADER_WAIT;
					end
				end
				SCHED_HEADER_WAIT: begin
					if (start_sample) begin
						// mux2 marks the sample frame on the line
						add_mpx2 <= 1'b1;
						shot     <= 1'b1;
						state    <= SCHED_SAMPLE_WAIT;
					end
				end
				SCHED_SAMPLE_WAIT: begin
					if (confirm) begin
						add_mpx2 <= 1'b0;
						rdy      <= 1'b0;
						state    <= SCHED_IDLE;
					end
				end
				default: begin
					state <= SCHED_IDLE;
				end
			endcase
		end
	end

	// frame word stays put until the next shot
	always_ff @(posedge clock) begin
		if (start_pair) begin
			frame.kind    <= FRAME_HEADER;
			frame.payload <= header_byte;
		end else if (start_sample) begin
			frame.kind    <= FRAME_SAMPLE;
			frame.payload <= sample.value;
		end
	end

endmodule

`default_nettype wire

// ==== source/line_interface.sv ====
// Serial line interface
`default_nettype none
`timescale 1ns/1ps

module line_interface (
	input  wire                             clock,
	input  wire                             rst_n,
	input  wire                             shot,
	input  telemetry_pkg::tx_frame_t        frame,
	input  wire                             dsr,
	input  wire                             tx_end,
	output logic                            load_shift,
	output logic [7:0]                      shift_data,
	output logic                            confirm,
	output telemetry_pkg::line_status_t     status
);

	import telemetry_pkg::*;

	line_state_t state;
	logic        error_q;
	logic        accept;

	// dsr is looked at once, in the cycle after shot
	assign accept = (state == LINE_LOAD) && dsr;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state      <= LINE_IDLE;
			load_shift <= 1'b0;
			confirm    <= 1'b0;
			error_q    <= 1'b0;
		end else begin
			// both strobes last one cycle
			load_shift <= 1'b0;
			confirm    <= 1'b0;
			case (state)
				LINE_IDLE: begin
					if (shot) begin
						state <= LINE_LOAD;
					end
				end
				LINE_LOAD: begin
					if (accept) begin
						// holding register fills at this edge
						error_q    <= 1'b0;
						load_shift <= 1'b1;
						state      <= LINE_SEND;
					end else begin
						// refused frame is dropped and reported done
						error_q <= 1'b1;
						confirm <= 1'b1;
						state   <= LINE_IDLE;
					end
				end
				LINE_SEND: begin
					// shifter has the byte now
					state <= LINE_WAIT_END;
				end
				LINE_WAIT_END: begin
					// stop bit finished
					if (tx_end) begin
						confirm <= 1'b1;
						state   <= LINE_IDLE;
					end
				end
				default: begin
					state <= LINE_IDLE;
				end
			endcase
		end
	end

	// holding register
	always_ff @(posedge clock) begin
		if (accept) begin
			shift_data <= frame.payload;
		end
	end

	assign status.busy  = (state != LINE_IDLE);
	assign status.error = error_q;

endmodule

`default_nettype wire

// ==== source/serial_shifter.sv ====
// Serial frame shifter
`default_nettype none
`timescale 1ns/1ps

module serial_shifter (
	input  wire        clock,
	input  wire        rst_n,
	input  wire        load_shift,
	input  wire  [7:0] shift_data,
	output logic       data_out,
	output logic       tx_end
);

	import telemetry_pkg::*;

	shift_state_t           state;
	logic [TICK_W-1:0]      tick_cnt;
	logic [BIT_W-1:0]       bit_idx;
	logic [FRAME_BITS-1:0]  shift_reg;
	logic                   bit_done;
	logic                   last_bit;

	// end of the current bit period
	assign bit_done = (state == SHIFT_RUN) && (tick_cnt == TICK_W'(BIT_TICKS - 1));
	// stop bit is the last one of the frame
	assign last_bit = (bit_idx == BIT_W'(FRAME_BITS - 1));

	assign tx_end = bit_done && last_bit;

	// line idles high, otherwise the top of the shift register
	assign data_out = (state == SHIFT_RUN) ? shift_reg[FRAME_BITS-1] : 1'b1;

	// bit timing and frame position
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state    <= SHIFT_IDLE;
			tick_cnt <= '0;
			bit_idx  <= '0;
		end else begin
			case (state)
				SHIFT_IDLE: begin
					if (load_shift) begin
						tick_cnt <= '0;
						bit_idx  <= '0;
						state    <= SHIFT_RUN;
					end
				end
				SHIFT_RUN: begin
					if (bit_done) begin
						tick_cnt <= '0;
						if (last_bit) begin
							state <= SHIFT_IDLE;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end else begin
						tick_cnt <= tick_cnt + 1'b1;
					end
				end
				default: begin
					state <= SHIFT_IDLE;
				end
			endcase
		end
	end

	// start bit on top, data msb first, stop bit at the bottom
	always_ff @(posedge clock) begin
		if (state == SHIFT_IDLE && load_shift) begin
			shift_reg <= {1'b0, shift_data, 1'b1};
		end else if (bit_done) begin
			shift_reg <= {shift_reg[FRAME_BITS-2:0], 1'b1};
		end
	end

endmodule

`default_nettype wire

// ==== source/telemetry_tx_top.sv ====
// Telemetry transmitter top level
`default_nettype none
`timescale 1ns/1ps

module telemetry_tx_top (
	input  wire                                 clock,
	input  wire                                 rst_n,
	input  wire                                 eoc,
	input  wire  [7:0]                          data_in,
	input  wire                                 dsr,
	output wire                                 soc,
	output wire                                 load_dato,
	output wire                                 mux_en,
	output wire                                 add_mpx2,
	output wire  [telemetry_pkg::CHAN_W-1:0]    canale,
	output wire                                 error,
	output wire                                 data_out
);

	import telemetry_pkg::*;

	// sequencer to scheduler
	sample_t      sample;
	wire          send_data;
	wire          rdy;

	// scheduler to line interface
	tx_frame_t    frame;
	wire          shot;
	wire          confirm;
	line_status_t status;

	// line interface to shifter
	wire          load_shift;
	wire [7:0]    shift_data;
	wire          tx_end;

	assign error = status.error;

	sample_sequencer u_sequencer (
		.clock     (clock),
		.rst_n     (rst_n),
		.eoc       (eoc),
		.data_in   (data_in),
		.rdy       (rdy),
		.soc       (soc),
		.load_dato (load_dato),
		.mux_en    (mux_en),
		.canale    (canale),
		.send_data (send_data),
		.sample    (sample)
	);

	frame_scheduler u_scheduler (
		.clock     (clock),
		.rst_n     (rst_n),
		.send_data (send_data),
		.sample    (sample),
		.confirm   (confirm),
		.rdy       (rdy),
		.shot      (shot),
		.add_mpx2  (add_mpx2),
		.frame     (frame)
	);

	line_interface u_line (
		.clock      (clock),
		.rst_n      (rst_n),
		.shot       (shot),
		.frame      (frame),
		.dsr        (dsr),
		.tx_end     (tx_end),
		.load_shift (load_shift),
		.shift_data (shift_data),
		.confirm    (confirm),
		.status     (status)
	);

	serial_shifter u_shifter (
		.clock      (clock),
		.rst_n      (rst_n),
		.load_shift (load_shift),
		.shift_data (shift_data),
		.data_out   (data_out),
		.tx_end     (tx_end)
	);

endmodule

`default_nettype wire

// ==== testbench/telemetry_tx_assertions.sv ====
// Transmitter property checks
`default_nettype none
`timescale 1ns/1ps

module telemetry_tx_assertions (
	input wire                               clock,
	input wire                               rst_n,
	input wire                               soc,
	input wire                               load_dato,
	input wire                               load_shift,
	input wire                               tx_end,
	input wire                               error,
	input wire [telemetry_pkg::TICK_W-1:0]   tick_cnt
);

	// latch pulse only inside an active conversion
	latch_in_conversion: assert property (
		@(posedge clock) disable iff (!rst_n) load_dato |-> soc
	) else $error("load_dato high while soc is low");

	// a new frame never lands on the stop bit of the last one
	no_load_at_end: assert property (
		@(posedge clock) disable iff (!rst_n) !(tx_end && load_shift)
	) else $error("tx_end and load_shift high together");

	// bit period counter climbs one per cycle from zero
	tick_steps_by_one: assert property (
		@(posedge clock) disable iff (!rst_n)
			tick_cnt != '0 |-> tick_cnt == $past(tick_cnt) + 1'b1
	) else $error("bit counter skipped or held a count");

	// accepted frame clears error in the same edge
	no_load_with_error: assert property (
		@(posedge clock) disable iff (!rst_n) !(error && load_shift)
	) else $error("error and load_shift high together");

endmodule

`default_nettype wire

// ==== testbench/telemetry_tx_tb.sv ====
// Telemetry transmitter testbench
`default_nettype none
`timescale 1ns/1ps

module telemetry_tx_tb;

	import telemetry_pkg::*;

	localparam int NUM_CASES = 14;
	// bound for every wait, in clock cycles
	localparam int WAIT_LIMIT = 64;

	logic       clock = 1'b0;
	logic       rst_n;
	logic       eoc;
	logic [7:0] data_in;
	logic       dsr;

	wire              soc;
	wire              load_dato;
	wire              mux_en;
	wire              add_mpx2;
	wire [CHAN_W-1:0] canale;
	wire              error;
	wire              data_out;

	// three words per case: dsr, conversion cycles, sample byte
	logic [7:0] case_mem [0:3*NUM_CASES-1];
	logic       fail_printed;
	logic       run_passed;

	telemetry_tx_top dut0 (
		.clock     (clock),
		.rst_n     (rst_n),
		.eoc       (eoc),
		.data_in   (data_in),
		.dsr       (dsr),
		.soc       (soc),
		.load_dato (load_dato),
		.mux_en    (mux_en),
		.add_mpx2  (add_mpx2),
		.canale    (canale),
		.error     (error),
		.data_out  (data_out)
	);

	bind telemetry_tx_top telemetry_tx_assertions u_assertions (
		.clock      (clock),
		.rst_n      (rst_n),
		.soc        (soc),
		.load_dato  (load_dato),
		.load_shift (load_shift),
		.tx_end     (tx_end),
		.error      (error),
		.tick_cnt   (u_shifter.tick_cnt)
	);

	// 4 ns period
	always #2 clock = ~clock;

	task automatic abort_run(input string what);
		$display("%s", what);
		fail_printed = 1'b1;
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic value_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		abort_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic expect_bit(input string name, input logic got, input logic exp);
		assert (got === exp) else value_mismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic wait_soc();
		int n;
		n = 0;
		while (soc !== 1'b1) begin
			@(negedge clock);
			n++;
			assert (n < WAIT_LIMIT) else abort_run("timeout waiting for soc to rise");
		end
	endtask

	task automatic wait_load_dato();
		int n;
		n = 0;
		while (load_dato !== 1'b1) begin
			@(negedge clock);
			n++;
			assert (n < WAIT_LIMIT) else abort_run("timeout waiting for load_dato");
		end
	endtask

	// optionally watch that the line stays idle meanwhile
	task automatic wait_mpx(input logic level, input logic line_quiet);
		int n;
		n = 0;
		while (add_mpx2 !== level) begin
			if (line_quiet) begin
				assert (data_out === 1'b1)
					else abort_run("start bit sent although dsr refused the frame");
			end
			@(negedge clock);
			n++;
			assert (n < WAIT_LIMIT) else abort_run("timeout waiting for add_mpx2 to change");
		end
	endtask

	// converter model, eoc high for len cycles, byte valid before eoc falls
	task automatic run_conversion(input int len, input logic [7:0] value);
		@(negedge clock);
		eoc = 1'b1;
		repeat (len - 1) @(negedge clock);
		data_in = value;
		@(negedge clock);
		eoc = 1'b0;
	endtask

	// samples each bit in its middle, counted from the start bit edge
	task automatic decode_frame(input string name, input logic [7:0] exp_byte,
		input logic exp_mpx);
		logic [7:0] got;
		int         n;
		n = 0;
		while (data_out !== 1'b0) begin
			@(negedge clock);
			n++;
			assert (n < WAIT_LIMIT) else abort_run("timeout waiting for a start bit");
		end
		// first low sample is half a cycle in
		repeat (BIT_TICKS / 2 - 1) @(negedge clock);
		assert (data_out === 1'b0) else abort_run("start bit ended too early");
		expect_bit("add_mpx2", add_mpx2, exp_mpx);
		for (int b = 7; b >= 0; b--) begin
			repeat (BIT_TICKS) @(negedge clock);
			got[b] = data_out;
		end
		repeat (BIT_TICKS) @(negedge clock);
		assert (data_out === 1'b1) else abort_run("stop bit missing");
		expect_bit("add_mpx2", add_mpx2, exp_mpx);
		assert (got === exp_byte) else value_mismatch(name, 32'(got), 32'(exp_byte));
	endtask

	initial begin
		logic [CHAN_W-1:0] ch;
		logic              case_dsr;
		int                case_len;
		logic [7:0]        case_byte;
		fail_printed = 1'b0;
		run_passed   = 1'b0;
		rst_n        = 1'b0;
		eoc          = 1'b0;
		dsr          = 1'b0;
		void'($urandom(42));
		data_in = 8'($urandom());
		$readmemh("testbench/telemetry_cases.txt", case_mem);

		repeat (8) @(negedge clock);
		// outputs still hold their reset values here
		expect_bit("soc", soc, 1'b0);
		expect_bit("load_dato", load_dato, 1'b0);
		expect_bit("mux_en", mux_en, 1'b0);
		expect_bit("add_mpx2", add_mpx2, 1'b0);
		expect_bit("error", error, 1'b0);
		expect_bit("data_out", data_out, 1'b1);
		assert (canale === '0) else value_mismatch("canale", 32'(canale), 32'h0);
		rst_n = 1'b1;

		for (int i = 0; i < NUM_CASES; i++) begin
			case_dsr  = case_mem[3*i][0];
			case_len  = int'(case_mem[3*i+1]);
			case_byte = case_mem[3*i+2];
			// channel counts every conversion and wraps at eight
			ch  = CHAN_W'(i % NUM_CHANNELS);
			dsr = case_dsr;

			wait_soc();
			expect_bit("load_dato", load_dato, 1'b0);
			expect_bit("mux_en", mux_en, 1'b1);
			assert (canale === ch) else value_mismatch("canale", 32'(canale), 32'(ch));

			run_conversion(case_len, case_byte);
			wait_load_dato();
			expect_bit("soc", soc, 1'b1);
			assert (canale === ch) else value_mismatch("canale", 32'(canale), 32'(ch));
			// byte is taken at the next rising edge
			@(negedge clock);
			data_in = 8'($urandom());

			if (case_dsr) begin
				decode_frame("data_out header byte", {HEADER_TAG, 1'b0, ch}, 1'b0);
				decode_frame("data_out sample byte", case_byte, 1'b1);
				wait_mpx(1'b0, 1'b0);
			end else begin
				wait_mpx(1'b1, 1'b1);
				wait_mpx(1'b0, 1'b1);
			end
			// pair is over, refused frames leave error set
			expect_bit("error", error, !case_dsr);
		end

		run_passed = 1'b1;
		$display("SIMULATION PASSED");
		$finish;
	end

	// run stopped by something other than a testbench check
	final begin
		if (!run_passed && !fail_printed) begin
			$display("SIMULATION FAILED");
		end
	end

endmodule

`default_nettype wire

// ==== testbench/telemetry_cases.txt ====
// columns: dsr level, conversion length in cycles, sample byte (all hex)
// one line per conversion, channel follows the line number modulo 8
1 03 A5
1 05 3C
0 04 FF
1 02 00
1 07 81
0 01 5A
0 06 66
1 03 7E
1 04 C3
1 0A 18
0 02 E7
1 05 99
1 01 01
1 09 F0

// ==== list.f ====
source/telemetry_pkg.sv
source/sample_sequencer.sv
source/frame_scheduler.sv
source/line_interface.sv
source/serial_shifter.sv
source/telemetry_tx_top.sv
testbench/telemetry_tx_assertions.sv
testbench/telemetry_tx_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the telemetry transmitter testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f list.f --top-module telemetry_tx_tb -o telemetry_tx_sim \
	&& ./obj_dir/telemetry_tx_sim | tee /dev/stderr | grep -qF "SIMULATION PASSED" \
	&& echo "run ok" \
	|| { echo "run failed"; exit 1; }
